/* Makefile */
TOP = vde_tb

sim:
	verilator --binary -Wno-fatal --top-module $(TOP) -f tb.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q '>>> PASS'

clean:
	rm -rf obj_dir

.PHONY: sim clean

/* hdl/heap_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module heap_ctrl (
    input  wire                        clk,
    input  wire                        reset,
    input  wire vde_pkg::vde_cfg_t     cfg,
    input  wire                        init_start,
    input  wire                        cmd_valid,
    input  wire vde_pkg::vde_cmd_t     cmd,
    input  wire                        request,
    output logic                       decision_valid,
    output vde_pkg::decision_t         decision,
    output logic                       all_assigned,
    output logic                       busy,
    output vde_pkg::heap_port_t        heap_a,
    output vde_pkg::heap_port_t        heap_b,
    output vde_pkg::heap_idx_t         heap_raddr_a,
    output vde_pkg::heap_idx_t         heap_raddr_b,
    input  wire vde_pkg::heap_entry_t  heap_rdata_a,
    input  wire vde_pkg::heap_entry_t  heap_rdata_b,
    output vde_pkg::pos_port_t         pos_a,
    output vde_pkg::pos_port_t         pos_b,
    output vde_pkg::heap_idx_t         pos_raddr,
    input  wire vde_pkg::heap_idx_t    pos_rdata
);

    vde_pkg::ctrl_state_e         state_q, state_d;
    vde_pkg::heap_idx_t           heap_size_q, heap_size_d;
    vde_pkg::heap_idx_t           idx_q, idx_d;
    logic                         moved_q, moved_d;
    logic [vde_pkg::max_vars-1:0] phase_q;
    vde_pkg::vde_cmd_t            pend_q;
    // Entry travelling through the heap during a bubble
    vde_pkg::heap_entry_t         cur_q, cur_d;

    vde_pkg::heap_idx_t   left_idx, right_idx, parent_idx, swap_slot;
    vde_pkg::heap_idx_t   child_idx, root_slot, pend_slot;
    vde_pkg::heap_entry_t child_entry, bumped;
    logic                 is_assign, is_bump, cmd_ok, left_wins, right_wins, finish_down;
    // One bit wider so the right child of the last slot does not wrap to the root
    logic [vde_pkg::idx_w:0] right_wide;

    function automatic logic better(input vde_pkg::heap_entry_t a,
                                    input vde_pkg::heap_entry_t b);
        return (a.score > b.score) || (a.score == b.score && a.var_id < b.var_id);
    endfunction

    function automatic vde_pkg::heap_idx_t slot_of(input vde_pkg::var_id_t v);
        return vde_pkg::heap_idx_t'(v - 1'b1);
    endfunction

    // ==================================================
    // Heap arithmetic
    // ==================================================
    assign is_assign  = pend_q.op == vde_pkg::op_assign;
    assign is_bump    = pend_q.op == vde_pkg::op_bump;
    assign cmd_ok     = cmd.var_id != '0 && cmd.var_id <= cfg.max_var;
    assign left_idx   = (idx_q << 1) + 1'b1;
    assign right_wide = {idx_q, 1'b0} + 2'd2;
    assign right_idx  = right_wide[vde_pkg::idx_w-1:0];
    assign parent_idx = (idx_q - 1'b1) >> 1;
    // Last live slot when hiding, first hidden slot when unhiding
    assign swap_slot  = is_assign ? heap_size_q - 1'b1 : heap_size_q;
    assign root_slot  = slot_of(heap_rdata_a.var_id);
    assign pend_slot  = slot_of(pend_q.var_id);
    assign bumped     = '{score: heap_rdata_a.score + cfg.bump_step,
                          var_id: heap_rdata_a.var_id};

    assign left_wins   = left_idx < heap_size_q && better(heap_rdata_a, cur_q);
    assign right_wins  = right_wide < heap_size_q && better(heap_rdata_b, cur_q)
                         && (!left_wins || better(heap_rdata_b, heap_rdata_a));
    assign child_idx   = right_wins ? right_idx : left_idx;
    assign child_entry = right_wins ? heap_rdata_b : heap_rdata_a;
    // A hidden slot refilled from the end sinks if it did not rise
    assign finish_down = is_assign && !moved_q;

    assign busy = !(state_q inside {vde_pkg::st_idle, vde_pkg::st_dec_read,
                                    vde_pkg::st_dec_out});

    // Root stays on read port a while the decision is shown
    assign decision_valid = state_q == vde_pkg::st_dec_out && heap_size_q != '0;
    assign all_assigned   = state_q == vde_pkg::st_dec_out && heap_size_q == '0;
    assign decision       = '{var_id: heap_rdata_a.var_id,
                              phase: phase_q[root_slot[vde_pkg::mem_aw-1:0]]};

    // Every heap write moves its entry, so the position write follows it
    assign pos_a = '{we: heap_a.we, addr: slot_of(heap_a.data.var_id), data: heap_a.addr};
    assign pos_b = '{we: heap_b.we, addr: slot_of(heap_b.data.var_id), data: heap_b.addr};

    // ==================================================
    // State machine
    // ==================================================
    always_comb begin
        state_d      = state_q;
        heap_size_d  = heap_size_q;
        idx_d        = idx_q;
        moved_d      = moved_q;
        cur_d        = cur_q;
        heap_a       = '0;
        heap_b       = '0;
        heap_raddr_a = '0;
        heap_raddr_b = '0;
        pos_raddr    = slot_of(cmd.var_id);

        case (state_q)
            vde_pkg::st_idle, vde_pkg::st_dec_read, vde_pkg::st_dec_out: begin
                if (init_start) begin
                    state_d     = vde_pkg::st_init;
                    idx_d       = '0;
                    heap_size_d = cfg.max_var;
                end else if (cmd_valid && cmd_ok) begin
                    moved_d = 1'b0;
                    state_d = vde_pkg::st_pos_check;
                end else if (state_q == vde_pkg::st_idle) begin
                    if (request && !cmd_valid) begin
                        state_d = vde_pkg::st_dec_read;
                    end
                end else begin
                    state_d = request ? vde_pkg::st_dec_out : vde_pkg::st_idle;
                end
            end

            vde_pkg::st_init: begin
                heap_a = '{we: 1'b1, addr: idx_q,
                           data: '{score: '0, var_id: idx_q + 1'b1}};
                idx_d  = idx_q + 1'b1;
                if (idx_q == vde_pkg::heap_idx_t'(vde_pkg::max_vars - 1)) begin
                    state_d = vde_pkg::st_idle;
                end
            end

            vde_pkg::st_pos_check: begin
                idx_d = pos_rdata;
                // Assign needs a live variable, clear a hidden one
                if (is_bump || (is_assign == (pos_rdata < heap_size_q))) begin
                    state_d = vde_pkg::st_swap_read;
                end else begin
                    state_d = vde_pkg::st_idle;
                end
            end

            vde_pkg::st_swap_read: begin
                heap_raddr_a = idx_q;
                heap_raddr_b = swap_slot;
                state_d      = vde_pkg::st_swap_write;
            end

            vde_pkg::st_swap_write: begin
                if (is_bump) begin
                    heap_a  = '{we: 1'b1, addr: idx_q, data: bumped};
                    cur_d   = bumped;
                    state_d = (idx_q < heap_size_q) ? vde_pkg::st_up_read : vde_pkg::st_idle;
                end else begin
                    heap_a = '{we: 1'b1, addr: idx_q, data: heap_rdata_b};
                    heap_b = '{we: 1'b1, addr: swap_slot, data: heap_rdata_a};
                    if (is_assign) begin
                        heap_size_d = heap_size_q - 1'b1;
                        cur_d       = heap_rdata_b;
                        state_d     = (idx_q < swap_slot) ? vde_pkg::st_up_read
                                                          : vde_pkg::st_idle;
                    end else begin
                        heap_size_d = heap_size_q + 1'b1;
                        cur_d       = heap_rdata_a;
                        idx_d       = swap_slot;
                        state_d     = vde_pkg::st_up_read;
                    end
                end
            end

            vde_pkg::st_up_read: begin
                heap_raddr_a = parent_idx;
                if (idx_q == '0) begin
                    state_d = finish_down ? vde_pkg::st_down_read : vde_pkg::st_idle;
                end else begin
                    state_d = vde_pkg::st_up_cmp;
                end
            end

            vde_pkg::st_up_cmp: begin
                if (better(cur_q, heap_rdata_a)) begin
                    heap_a  = '{we: 1'b1, addr: idx_q, data: heap_rdata_a};
                    heap_b  = '{we: 1'b1, addr: parent_idx, data: cur_q};
                    idx_d   = parent_idx;
                    moved_d = 1'b1;
                    state_d = vde_pkg::st_up_read;
                end else begin
                    state_d = finish_down ? vde_pkg::st_down_read : vde_pkg::st_idle;
                end
            end

            vde_pkg::st_down_read: begin
                heap_raddr_a = left_idx;
                heap_raddr_b = right_idx;
                state_d      = vde_pkg::st_down_cmp;
            end

            vde_pkg::st_down_cmp: begin
                if (left_wins || right_wins) begin
                    heap_a  = '{we: 1'b1, addr: idx_q, data: child_entry};
                    heap_b  = '{we: 1'b1, addr: child_idx, data: cur_q};
                    idx_d   = child_idx;
                    state_d = vde_pkg::st_down_read;
                end else begin
                    state_d = vde_pkg::st_idle;
                end
            end

            default: state_d = vde_pkg::st_idle;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state_q     <= vde_pkg::st_idle;
            heap_size_q <= '0;
            idx_q       <= '0;
            moved_q     <= 1'b0;
            phase_q     <= '0;
        end else begin
            state_q     <= state_d;
            heap_size_q <= heap_size_d;
            idx_q       <= idx_d;
            moved_q     <= moved_d;
            if (!busy && init_start) begin
                phase_q <= '0;
            end else if (state_q == vde_pkg::st_pos_check && is_assign) begin
                phase_q[pend_slot[vde_pkg::mem_aw-1:0]] <= pend_q.value;
            end
        end
    end

    // Holds the last command offered while idle, which is the accepted one
    always_ff @(posedge clk) begin
        cur_q <= cur_d;
        if (!busy) begin
            pend_q <= cmd;
        end
    end

endmodule

`default_nettype wire

/* hdl/heap_store.sv */
`timescale 1ns/10ps
`default_nettype none

module heap_store (
    input  wire                        clk,
    input  wire vde_pkg::heap_port_t   heap_a,
    input  wire vde_pkg::heap_port_t   heap_b,
    input  wire vde_pkg::heap_idx_t    heap_raddr_a,
    input  wire vde_pkg::heap_idx_t    heap_raddr_b,
    output vde_pkg::heap_entry_t       heap_rdata_a,
    output vde_pkg::heap_entry_t       heap_rdata_b,
    input  wire vde_pkg::pos_port_t    pos_a,
    input  wire vde_pkg::pos_port_t    pos_b,
    input  wire vde_pkg::heap_idx_t    pos_raddr,
    output vde_pkg::heap_idx_t         pos_rdata
);

    // Heap slots, and slot of each variable indexed by number minus one
    vde_pkg::heap_entry_t heap_mem [vde_pkg::max_vars];
    vde_pkg::heap_idx_t   pos_mem  [vde_pkg::max_vars];

    logic [vde_pkg::mem_aw-1:0] heap_addr_a;
    logic [vde_pkg::mem_aw-1:0] heap_addr_b;
    logic [vde_pkg::mem_aw-1:0] pos_addr_a;
    logic [vde_pkg::mem_aw-1:0] pos_addr_b;

    // Shared address per port, write wins
    assign heap_addr_a = heap_a.we ? heap_a.addr[vde_pkg::mem_aw-1:0]
                                   : heap_raddr_a[vde_pkg::mem_aw-1:0];
    assign heap_addr_b = heap_b.we ? heap_b.addr[vde_pkg::mem_aw-1:0]
                                   : heap_raddr_b[vde_pkg::mem_aw-1:0];
    assign pos_addr_a  = pos_a.we ? pos_a.addr[vde_pkg::mem_aw-1:0]
                                  : pos_raddr[vde_pkg::mem_aw-1:0];
    assign pos_addr_b  = pos_b.addr[vde_pkg::mem_aw-1:0];

    always_ff @(posedge clk) begin
        if (heap_a.we) begin
            heap_mem[heap_addr_a] <= heap_a.data;
        end
        if (heap_b.we) begin
            heap_mem[heap_addr_b] <= heap_b.data;
        end
        if (pos_a.we) begin
            pos_mem[pos_addr_a] <= pos_a.data;
        end
        if (pos_b.we) begin
            pos_mem[pos_addr_b] <= pos_b.data;
        end
        heap_rdata_a <= heap_mem[heap_addr_a];
        heap_rdata_b <= heap_mem[heap_addr_b];
        pos_rdata    <= pos_mem[pos_addr_a];
    end

endmodule

`default_nettype wire

/* hdl/vde_config.sv */
`timescale 1ns/10ps
`default_nettype none

module vde_config (
    input  wire                   clk,
    input  wire                   reset,
    input  wire vde_pkg::wb_req_t wb_req,
    output vde_pkg::wb_rsp_t      wb_rsp,
    input  wire                   busy,
    output vde_pkg::vde_cfg_t     cfg,
    output logic                  init_start
);

    logic             ack_q;
    logic [15:0]      rdat_q;
    logic             init_pending_q;
    logic             wb_hit;
    vde_pkg::var_id_t max_var_wr;

    // Only a cycle not yet acked is decoded
    assign wb_hit = wb_req.cyc && wb_req.stb && !ack_q;
    assign wb_rsp = '{ack: ack_q, dat: rdat_q};

    // Rebuild waits for the engine to go idle
    assign init_start = init_pending_q && !busy;

    // Variable count saturates at the heap capacity
    assign max_var_wr = (wb_req.dat > 16'(vde_pkg::max_vars)) ?
                        vde_pkg::var_id_t'(vde_pkg::max_vars) :
                        wb_req.dat[vde_pkg::idx_w-1:0];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ack_q          <= 1'b0;
            rdat_q         <= '0;
            init_pending_q <= 1'b0;
            cfg.max_var    <= '0;
            cfg.bump_step  <= vde_pkg::default_bump_step;
        end else begin
            ack_q <= wb_hit;
            if (init_start) begin
                init_pending_q <= 1'b0;
            end
            if (wb_hit && wb_req.we) begin
                case (wb_req.adr)
                    vde_pkg::reg_max_var: begin
                        cfg.max_var    <= max_var_wr;
                        init_pending_q <= 1'b1;
                    end
                    vde_pkg::reg_bump_step: cfg.bump_step <= wb_req.dat;
                    default: ;
                endcase
            end else if (wb_hit) begin
                case (wb_req.adr)
                    vde_pkg::reg_max_var:   rdat_q <= 16'(cfg.max_var);
                    vde_pkg::reg_bump_step: rdat_q <= cfg.bump_step;
                    default:                rdat_q <= '0;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/vde_pkg.sv */
`default_nettype none

package vde_pkg;

    // ==================================================
    // Sizes
    // ==================================================
    localparam int max_vars = 64;
    localparam int idx_w    = 7;
    localparam int act_w    = 16;
    // Address width of the heap and position arrays
    localparam int mem_aw   = $clog2(max_vars);

    typedef logic [idx_w-1:0] heap_idx_t;
    typedef logic [idx_w-1:0] var_id_t;
    typedef logic [act_w-1:0] score_t;

    // Higher score first, lower variable number breaks ties
    typedef struct packed {
        score_t  score;
        var_id_t var_id;
    } heap_entry_t;

    typedef enum logic [1:0] {
        op_assign,
        op_clear,
        op_bump
    } cmd_op_e;

    typedef struct packed {
        cmd_op_e op;
        var_id_t var_id;
        logic    value;
    } vde_cmd_t;

    typedef struct packed {
        var_id_t var_id;
        logic    phase;
    } decision_t;

    // ==================================================
    // Wishbone and configuration
    // ==================================================
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [1:0]  adr;
        logic [15:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [15:0] dat;
    } wb_rsp_t;

    typedef struct packed {
        var_id_t max_var;
        score_t  bump_step;
    } vde_cfg_t;

    localparam logic [1:0] reg_max_var   = 2'd0;
    localparam logic [1:0] reg_bump_step = 2'd1;
    localparam score_t     default_bump_step = 16'd16;

    // One write port of each memory
    typedef struct packed {
        logic        we;
        heap_idx_t   addr;
        heap_entry_t data;
    } heap_port_t;

    typedef struct packed {
        logic      we;
        heap_idx_t addr;
        heap_idx_t data;
    } pos_port_t;

    typedef enum logic [3:0] {
        st_idle,
        st_init,
        st_dec_read,
        st_dec_out,
        st_pos_check,
        st_swap_read,
        st_swap_write,
        st_up_read,
        st_up_cmp,
        st_down_read,
        st_down_cmp
    } ctrl_state_e;

endpackage

`default_nettype wire

/* hdl/vde_top.sv */
`timescale 1ns/10ps
`default_nettype none

module vde_top (
    input  wire                    clk,
    input  wire                    reset,
    input  wire vde_pkg::wb_req_t  wb_req,
    output vde_pkg::wb_rsp_t       wb_rsp,
    input  wire                    cmd_valid,
    input  wire vde_pkg::vde_cmd_t cmd,
    input  wire                    request,
    output logic                   decision_valid,
    output vde_pkg::decision_t     decision,
    output logic                   all_assigned,
    output logic                   busy
);

    vde_pkg::vde_cfg_t    cfg;
    logic                 init_start;
    vde_pkg::heap_port_t  heap_a, heap_b;
    vde_pkg::heap_idx_t   heap_raddr_a, heap_raddr_b;
    vde_pkg::heap_entry_t heap_rdata_a, heap_rdata_b;
    vde_pkg::pos_port_t   pos_a, pos_b;
    vde_pkg::heap_idx_t   pos_raddr, pos_rdata;

    vde_config i_config (
        .clk        (clk),
        .reset      (reset),
        .wb_req     (wb_req),
        .wb_rsp     (wb_rsp),
        .busy       (busy),
        .cfg        (cfg),
        .init_start (init_start)
    );

    heap_ctrl i_ctrl (
        .clk            (clk),
        .reset          (reset),
        .cfg            (cfg),
        .init_start     (init_start),
        .cmd_valid      (cmd_valid),
        .cmd            (cmd),
        .request        (request),
        .decision_valid (decision_valid),
        .decision       (decision),
        .all_assigned   (all_assigned),
        .busy           (busy),
        .heap_a         (heap_a),
        .heap_b         (heap_b),
        .heap_raddr_a   (heap_raddr_a),
        .heap_raddr_b   (heap_raddr_b),
        .heap_rdata_a   (heap_rdata_a),
        .heap_rdata_b   (heap_rdata_b),
        .pos_a          (pos_a),
        .pos_b          (pos_b),
        .pos_raddr      (pos_raddr),
        .pos_rdata      (pos_rdata)
    );

    heap_store i_store (
        .clk          (clk),
        .heap_a       (heap_a),
        .heap_b       (heap_b),
        .heap_raddr_a (heap_raddr_a),
        .heap_raddr_b (heap_raddr_b),
        .heap_rdata_a (heap_rdata_a),
        .heap_rdata_b (heap_rdata_b),
        .pos_a        (pos_a),
        .pos_b        (pos_b),
        .pos_raddr    (pos_raddr),
        .pos_rdata    (pos_rdata)
    );

endmodule

`default_nettype wire

/* tb.f */
hdl/vde_pkg.sv
hdl/vde_config.sv
hdl/heap_store.sv
hdl/heap_ctrl.sv
hdl/vde_top.sv
tb/tb_clock.sv
tb/vde_checker.sv
tb/vde_tb.sv

/* tb/tb_clock.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_clock (
    output logic clk,
    output logic reset
);

    // 10 ns period
    initial begin
        clk   = 1'b0;
        reset = 1'b1;
        forever #5 clk = ~clk;
    end

    // Reset spans eight rising edges
    initial begin
        repeat (8) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

`default_nettype wire

/* tb/vde_checker.sv */
`timescale 1ns/10ps
`default_nettype none

module vde_checker (
    input  wire                     clk,
    input  wire vde_pkg::wb_rsp_t   wb_rsp,
    input  wire                     busy,
    input  wire                     decision_valid,
    input  wire vde_pkg::decision_t decision,
    input  wire                     all_assigned,
    output int                      errors
);

    int    case_num    = 0;
    string case_label  = "";
    logic  case_failed = 1'b0;
    int    pass_count  = 0;
    int    fail_count  = 0;
    int    busy_run    = 0;
    int    busy_len    = 0;

    assign errors = fail_count;

    // Length of the last busy stretch, closed on the first idle edge
    always @(posedge clk) begin
        if (busy) begin
            busy_run <= busy_run + 1;
        end else if (busy_run != 0) begin
            busy_len <= busy_run;
            busy_run <= 0;
        end
    end

    // ==================================================
    // Per test bookkeeping
    // ==================================================
    task automatic begin_case(input int num, input string label);
        case_num    = num;
        case_label  = label;
        case_failed = 1'b0;
    endtask

    task automatic record_problem(input string text);
        $display("Test %0d %s: %s", case_num, case_label, text);
        case_failed = 1'b1;
    endtask

    task automatic value_equal(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error: test %0d %s, %s is 0x%0h, expected 0x%0h",
                     case_num, case_label, name, got, exp);
            case_failed = 1'b1;
        end
    endtask

    task automatic finish_case();
        if (case_failed) begin
            fail_count++;
            $display("Test %0d %s: failed", case_num, case_label);
        end else begin
            pass_count++;
            $display("Test %0d %s: ok", case_num, case_label);
        end
    endtask

    task automatic print_totals();
        $display("Tests run %0d, passed %0d, failed %0d",
                 pass_count + fail_count, pass_count, fail_count);
    endtask

    // ==================================================
    // Comparisons against the DUT outputs
    // ==================================================
    task automatic verify_readback(input logic [15:0] exp);
        value_equal("wb_rsp.dat", 32'(wb_rsp.dat), 32'(exp));
    endtask

    task automatic audit_init_length();
        value_equal("busy cycles of init", busy_len, vde_pkg::max_vars);
    endtask

    task automatic expect_busy(input logic exp);
        if (busy !== exp) begin
            if (exp) begin
                record_problem("command was not accepted, busy stayed low");
            end else begin
                record_problem("out of range command made the engine busy");
            end
        end
    endtask

    task automatic inspect_decision(input logic exp_all, input logic [7:0] exp_var,
                                    input logic exp_phase, input int latency);
        if (!(decision_valid || all_assigned)) begin
            record_problem("no decision and no all_assigned after the request");
        end else begin
            value_equal("decision latency", latency, 2);
            value_equal("all_assigned", 32'(all_assigned), 32'(exp_all));
            value_equal("decision_valid", 32'(decision_valid), 32'(!exp_all));
            if (!exp_all) begin
                value_equal("decision.var_id", 32'(decision.var_id), 32'(exp_var));
                value_equal("decision.phase", 32'(decision.phase), 32'(exp_phase));
            end
        end
        // Decisions never raise busy
        value_equal("busy", 32'(busy), 32'd0);
    endtask

endmodule

`default_nettype wire

/* tb/vde_input.txt */
// Columns in 8 hex digits: op(1) flag(1) var or register(2) data(4)
// op 1 cfg write, 2 cfg read with expected data, 3 assign (flag is the value), 4 clear,
// 5 bump, 6 decide (var and flag give expected variable and phase), 7 decide all assigned
10000008
10010005
20000008
20010005
60010000
31010000
60020000
40010000
61010000
50060000
50060000
60060000
50030000
50030000
50030000
60030000
31010000
30020000
31030000
30040000
30050000
31060000
31070000
30080000
70000000
40060000
61060000
50020000
50020000
50020000
61060000
40020000
60020000
30000000
50090000
40000000
60020000

/* tb/vde_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module vde_tb;

    localparam int stim_depth   = 64;
    localparam int decide_limit = 16;

    // Operation codes in the top digit of each input word
    localparam logic [3:0] code_cfg_write  = 4'h1;
    localparam logic [3:0] code_cfg_read   = 4'h2;
    localparam logic [3:0] code_assign     = 4'h3;
    localparam logic [3:0] code_clear      = 4'h4;
    localparam logic [3:0] code_bump       = 4'h5;
    localparam logic [3:0] code_decide     = 4'h6;
    localparam logic [3:0] code_decide_all = 4'h7;

    logic               clk;
    logic               reset;
    vde_pkg::wb_req_t   wb_req;
    vde_pkg::wb_rsp_t   wb_rsp;
    logic               cmd_valid;
    vde_pkg::vde_cmd_t  cmd;
    logic               request;
    logic               decision_valid;
    vde_pkg::decision_t decision;
    logic               all_assigned;
    logic               busy;
    int                 errors;

    logic [31:0] stim [stim_depth];
    int          line_count;
    int          watchdog_cycles;
    int          cfg_max_var;

    tb_clock i_clock (
        .clk   (clk),
        .reset (reset)
    );

    vde_top i_dut (
        .clk            (clk),
        .reset          (reset),
        .wb_req         (wb_req),
        .wb_rsp         (wb_rsp),
        .cmd_valid      (cmd_valid),
        .cmd            (cmd),
        .request        (request),
        .decision_valid (decision_valid),
        .decision       (decision),
        .all_assigned   (all_assigned),
        .busy           (busy)
    );

    vde_checker i_checker (
        .clk            (clk),
        .wb_rsp         (wb_rsp),
        .busy           (busy),
        .decision_valid (decision_valid),
        .decision       (decision),
        .all_assigned   (all_assigned),
        .errors         (errors)
    );

    // ==================================================
    // Bus and command drivers
    // ==================================================
    task automatic wb_access(input logic we, input logic [1:0] adr, input logic [15:0] dat);
        @(posedge clk);
        wb_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
        do begin
            @(negedge clk);
        end while (!wb_rsp.ack);
        // Read data comes with the ack
        if (!we) begin
            i_checker.verify_readback(dat);
        end
        @(posedge clk);
        wb_req <= '0;
    endtask

    task automatic send_command(input vde_pkg::cmd_op_e op, input logic [7:0] var_num,
                                input logic value);
        logic ignored;
        ignored = (var_num == 8'd0) || (int'(var_num) > cfg_max_var);
        @(posedge clk);
        cmd_valid <= 1'b1;
        cmd       <= '{op: op, var_id: var_num[vde_pkg::idx_w-1:0], value: value};
        @(posedge clk);
        cmd_valid <= 1'b0;
        @(negedge clk);
        if (ignored) begin
            repeat (3) begin
                i_checker.expect_busy(1'b0);
                @(negedge clk);
            end
        end else begin
            i_checker.expect_busy(1'b1);
            while (busy) @(negedge clk);
        end
    endtask

    task automatic request_decision(input logic exp_all, input logic [7:0] exp_var,
                                    input logic exp_phase);
        int waited;
        @(posedge clk);
        request <= 1'b1;
        // Acceptance edge
        @(posedge clk);
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!(decision_valid || all_assigned) && waited < decide_limit);
        i_checker.inspect_decision(exp_all, exp_var, exp_phase, waited);
        @(posedge clk);
        request <= 1'b0;
        @(posedge clk);
    endtask

    task automatic run_line(input int num, input logic [31:0] word);
        logic [3:0]  code;
        logic        flag;
        logic [7:0]  arg;
        logic [15:0] data;
        code = word[31:28];
        flag = word[24];
        arg  = word[23:16];
        data = word[15:0];
        case (code)
            code_cfg_write: begin
                i_checker.begin_case(num, "cfg write");
                wb_access(1'b1, arg[1:0], data);
                if (arg[1:0] == vde_pkg::reg_max_var) begin
                    cfg_max_var = (int'(data) > vde_pkg::max_vars) ? vde_pkg::max_vars
                                                                   : int'(data);
                    // Rebuild starts a couple of cycles after the ack
                    while (!busy) @(negedge clk);
                    while (busy) @(negedge clk);
                    @(negedge clk);
                    i_checker.audit_init_length();
                end
            end
            code_cfg_read: begin
                i_checker.begin_case(num, "cfg read");
                wb_access(1'b0, arg[1:0], data);
            end
            code_assign: begin
                i_checker.begin_case(num, "assign");
                send_command(vde_pkg::op_assign, arg, flag);
            end
            code_clear: begin
                i_checker.begin_case(num, "clear");
                send_command(vde_pkg::op_clear, arg, 1'b0);
            end
            code_bump: begin
                i_checker.begin_case(num, "bump");
                send_command(vde_pkg::op_bump, arg, 1'b0);
            end
            code_decide: begin
                i_checker.begin_case(num, "decide");
                request_decision(1'b0, arg, flag);
            end
            code_decide_all: begin
                i_checker.begin_case(num, "decide all assigned");
                request_decision(1'b1, 8'd0, 1'b0);
            end
            default: begin
                i_checker.begin_case(num, "unknown");
                i_checker.record_problem("input line holds an unknown operation code");
            end
        endcase
        i_checker.finish_case();
    endtask

    // ==================================================
    // Main sequence and watchdog
    // ==================================================
    initial begin
        int i;
        wb_req          = '0;
        cmd_valid       = 1'b0;
        cmd             = '0;
        request         = 1'b0;
        line_count      = 0;
        watchdog_cycles = 0;
        cfg_max_var     = 0;
        void'($urandom(32'h193dc99c));
        for (i = 0; i < stim_depth; i++) begin
            stim[i] = '0;
        end
        $readmemh("tb/vde_input.txt", stim);
        while (line_count < stim_depth && stim[line_count][31:28] != 4'h0) begin
            line_count++;
        end
        watchdog_cycles = line_count * vde_pkg::max_vars * 20;

        @(negedge reset);
        @(posedge clk);
        for (i = 0; i < line_count; i++) begin
            run_line(i + 1, stim[i]);
            repeat ($urandom % 4) @(posedge clk);
        end

        i_checker.print_totals();
        if (errors == 0 && line_count > 0) begin
            $display(">>> PASS");
        end else begin
            if (line_count == 0) begin
                $display("No stimulus lines were read from the input file");
            end
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin
        wait (watchdog_cycles != 0);
        repeat (watchdog_cycles) @(posedge clk);
        $display("Watchdog expired after %0d cycles with a test still running",
                 watchdog_cycles);
        $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire
